// ==== all.f ====
design/zx_input_pkg.sv
design/ps2_rx.sv
design/keyboard_matrix.sv
design/joystick_port.sv
design/io_read_port.sv
design/zx_input_top.sv
tests/tb_zx_input.sv

// ==== design/io_read_port.sv ====
module io_read_port
   import zx_input_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         io_req,
   input  logic [15:0]                  io_addr,
   input  logic                         ear,
   input  logic [KEY_ROWS*KEY_COLS-1:0] key_state,
   input  logic [7:0]                   joy_byte,
   output logic                         io_ack,
   output logic [7:0]                   io_data
);

   logic                req_q;      // Input register
   logic                req_d;      // Previous req_q, for the edge
   logic                req_rise;
   logic [1:0]          ear_sync;
   logic [KEY_COLS-1:0] col_held;   // Key held in any selected row
   logic [7:0]          ula_byte;
   logic [7:0]          rd_byte;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_q    <= 1'b0;
         req_d    <= 1'b0;
         ear_sync <= 2'b00;
      end else begin
         req_q    <= io_req;
         req_d    <= req_q;
         ear_sync <= {ear_sync[0], ear};
      end
   end

   assign req_rise = req_q & ~req_d;

   //////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////
   // A low address bit 8+r selects half-row r
   always_comb begin
      col_held = '0;
      for (int r = 0; r < KEY_ROWS; r++) begin
         if (!io_addr[8+r])
            col_held = col_held | key_state[r*KEY_COLS +: KEY_COLS];
      end
   end

   // Board has an inverting transistor on EAR
   assign ula_byte = {1'b1, ~ear_sync[1], 1'b1, ~col_held};

   always_comb begin
      if (!io_addr[0])
         rd_byte = ula_byte;                    // Any even port is the ULA
      else if (io_addr[7:0] == KEMPSTON_PORT)
         rd_byte = joy_byte;
      else
         rd_byte = 8'hFF;                       // Floating bus
   end

   // Captured once per request, later key changes do not disturb it
   always_ff @(posedge clk) begin
      if (req_rise)
         io_data <= rd_byte;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         io_ack <= 1'b0;
      else if (req_rise)
         io_ack <= 1'b1;                        // Data valid with ack
      else if (!req_q)
         io_ack <= 1'b0;                        // CPU has dropped req
   end

endmodule

// ==== design/joystick_port.sv ====
module joystick_port
   import zx_input_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       joyup,      // Pins are active low
   input  logic       joydown,
   input  logic       joyleft,
   input  logic       joyright,
   input  logic       joyfire,
   output logic [7:0] joy_byte    // 000 fire up down left right, active high
);

   logic [4:0]           pins;
   logic [4:0]           sync_a;
   logic [4:0]           sync_b;
   logic [4:0]           cand;       // Value being timed for stability
   logic [JOY_CNT_W-1:0] stab_cnt;

   // Same bit order as the Kempston byte
   assign pins = {joyfire, joyup, joydown, joyleft, joyright};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_a   <= 5'h1F;          // Released pins sit high
         sync_b   <= 5'h1F;
         cand     <= 5'h1F;
         stab_cnt <= '0;
         joy_byte <= 8'h00;
      end else begin
         sync_a <= pins;
         sync_b <= sync_a;
         if (sync_b != cand) begin
            cand     <= sync_b;      // New candidate, start timing again
            stab_cnt <= '0;
         end else if (stab_cnt != JOY_CNT_W'(JOY_STABLE_CYCLES)) begin
            stab_cnt <= stab_cnt + 1'b1;
         end else begin
            joy_byte <= {3'b000, ~cand};   // Held long enough, accept
         end
      end
   end

endmodule

// ==== design/keyboard_matrix.sv ====
module keyboard_matrix
   import zx_input_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [7:0]                   scan_code,
   input  logic                         scan_valid,
   output logic [KEY_ROWS*KEY_COLS-1:0] key_state
);

   localparam int IDX_W = $clog2(KEY_ROWS * KEY_COLS);

   logic             brk_pend;   // F0 seen
   logic             ext_pend;   // E0 seen
   logic             key_hit;    // Code is in the table
   logic [IDX_W-1:0] key_idx;    // row*5 + col

   //////////////////////////////////////////////////
   // Set-2 scancode to matrix position
   //////////////////////////////////////////////////
   always_comb begin
      key_hit = 1'b1;
      key_idx = '0;
      case (scan_code)
         // Row 0: CAPS SHIFT Z X C V
         8'h12: key_idx = 6'd0;    // Left shift as CAPS SHIFT
         8'h1A: key_idx = 6'd1;
         8'h22: key_idx = 6'd2;
         8'h21: key_idx = 6'd3;
         8'h2A: key_idx = 6'd4;
         // Row 1: A S D F G
         8'h1C: key_idx = 6'd5;
         8'h1B: key_idx = 6'd6;
         8'h23: key_idx = 6'd7;
         8'h2B: key_idx = 6'd8;
         8'h34: key_idx = 6'd9;
         // Row 2: Q W E R T
         8'h15: key_idx = 6'd10;
         8'h1D: key_idx = 6'd11;
         8'h24: key_idx = 6'd12;
         8'h2D: key_idx = 6'd13;
         8'h2C: key_idx = 6'd14;
         // Row 3: 1 2 3 4 5
         8'h16: key_idx = 6'd15;
         8'h1E: key_idx = 6'd16;
         8'h26: key_idx = 6'd17;
         8'h25: key_idx = 6'd18;
         8'h2E: key_idx = 6'd19;
         // Row 4: 0 9 8 7 6
         8'h45: key_idx = 6'd20;
         8'h46: key_idx = 6'd21;
         8'h3E: key_idx = 6'd22;
         8'h3D: key_idx = 6'd23;
         8'h36: key_idx = 6'd24;
         // Row 5: P O I U Y
         8'h4D: key_idx = 6'd25;
         8'h44: key_idx = 6'd26;
         8'h43: key_idx = 6'd27;
         8'h3C: key_idx = 6'd28;
         8'h35: key_idx = 6'd29;
         // Row 6: ENTER L K J H
         8'h5A: key_idx = 6'd30;
         8'h4B: key_idx = 6'd31;
         8'h42: key_idx = 6'd32;
         8'h3B: key_idx = 6'd33;
         8'h33: key_idx = 6'd34;
         // Row 7: SPACE SYM SHIFT M N B
         8'h29: key_idx = 6'd35;
         8'h59: key_idx = 6'd36;   // Right shift as SYMBOL SHIFT
         8'h3A: key_idx = 6'd37;
         8'h31: key_idx = 6'd38;
         8'h32: key_idx = 6'd39;
         default: key_hit = 1'b0;  // Unmapped
      endcase
   end

   //////////////////////////////////////////////////
   // Prefix tracking and pressed state
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         brk_pend  <= 1'b0;
         ext_pend  <= 1'b0;
         key_state <= '0;
      end else if (scan_valid) begin
         if (scan_code == PS2_BREAK) begin
            brk_pend <= 1'b1;
         end else if (scan_code == PS2_EXTEND) begin
            ext_pend <= 1'b1;
         end else begin
            // Extended keys have no place on the Spectrum
            if (key_hit && !ext_pend)
               key_state[key_idx] <= ~brk_pend;   // Make sets, break clears
            brk_pend <= 1'b0;
            ext_pend <= 1'b0;
         end
      end
   end

endmodule

// ==== design/ps2_rx.sv ====
module ps2_rx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   output logic [7:0] scan_code,
   output logic       scan_valid
);

   // Roughly 350 us at 28 MHz, well over one PS/2 bit period
   localparam int IDLE_W = 14;
   localparam logic [IDLE_W-1:0] IDLE_LIMIT = 14'd10000;

   logic [1:0]        clk_sync;    // PS/2 clock synchronizer
   logic [1:0]        data_sync;   // PS/2 data synchronizer
   logic              clk_prev;    // Edge register
   logic              fall;
   logic [9:0]        shreg;       // Start, data, parity; stop comes live
   logic [3:0]        bit_cnt;
   logic [IDLE_W-1:0] idle_cnt;
   logic [10:0]       frame;
   logic              frame_ok;

   // Lines idle high, so synchronizers come out of reset high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   assign fall = clk_prev & ~clk_sync[1];   // Device changes data on rise, we sample on fall

   // Whole frame as seen while sampling the stop bit
   assign frame    = {data_sync[1], shreg};
   assign frame_ok = ~frame[0]            // Start bit low
                   & frame[10]            // Stop bit high
                   & (^frame[9:1]);       // Odd parity over data plus parity bit

   // LSB first, so shift in from the top
   always_ff @(posedge clk) begin
      if (fall)
         shreg <= {data_sync[1], shreg[9:1]};
   end

   //////////////////////////////////////////////////
   // Bit counter, idle timeout, output strobe
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt    <= '0;
         idle_cnt   <= '0;
         scan_valid <= 1'b0;
      end else begin
         scan_valid <= 1'b0;
         if (fall) begin
            idle_cnt <= '0;
            if (bit_cnt == 4'd10) begin
               bit_cnt    <= '0;               // Stop bit, frame done
               scan_valid <= frame_ok;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else begin
            if (idle_cnt != IDLE_LIMIT)
               idle_cnt <= idle_cnt + 1'b1;
            else
               bit_cnt <= '0;                  // Drop a half-received frame
         end
      end
   end

   // Data byte sits in frame[8:1]
   always_ff @(posedge clk) begin
      if (fall && bit_cnt == 4'd10 && frame_ok)
         scan_code <= frame[8:1];
   end

endmodule

// ==== design/zx_input_pkg.sv ====
package zx_input_pkg;

   //////////////////////////////////////////////////
   // Keyboard matrix geometry
   //////////////////////////////////////////////////
   localparam int KEY_ROWS = 8;   // Half-rows, one per high address bit A8..A15
   localparam int KEY_COLS = 5;   // Keys per half-row, data bits D0..D4

   //////////////////////////////////////////////////
   // I/O ports
   //////////////////////////////////////////////////
   // ULA port is any even address, so only Kempston needs a number
   localparam logic [7:0] KEMPSTON_PORT = 8'h1F;

   //////////////////////////////////////////////////
   // PS/2 set-2 prefixes
   //////////////////////////////////////////////////
   localparam logic [7:0] PS2_BREAK  = 8'hF0;   // Key release follows
   localparam logic [7:0] PS2_EXTEND = 8'hE0;   // Extended key follows

   //////////////////////////////////////////////////
   // Joystick debounce
   //////////////////////////////////////////////////
   localparam int JOY_STABLE_CYCLES = 16;
   // Counter must be able to hold JOY_STABLE_CYCLES itself
   localparam int JOY_CNT_W = $clog2(JOY_STABLE_CYCLES + 1);

endpackage

// ==== design/zx_input_top.sv ====
module zx_input_top
   import zx_input_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ps2_clk,
   input  logic        ps2_data,
   input  logic        ear,
   input  logic        joyup,
   input  logic        joydown,
   input  logic        joyleft,
   input  logic        joyright,
   input  logic        joyfire,
   input  logic        io_req,
   input  logic [15:0] io_addr,
   output logic        io_ack,
   output logic [7:0]  io_data
);

   logic [7:0]                   scan_code;
   logic                         scan_valid;
   logic [KEY_ROWS*KEY_COLS-1:0] key_state;   // One bit per Spectrum key
   logic [7:0]                   joy_byte;

   //////////////////////////////////////////////////
   // Keyboard path
   //////////////////////////////////////////////////
   ps2_rx u_ps2_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .ps2_clk    (ps2_clk),
      .ps2_data   (ps2_data),
      .scan_code  (scan_code),
      .scan_valid (scan_valid)
   );

   keyboard_matrix u_keyboard_matrix (
      .clk        (clk),
      .rst_n      (rst_n),
      .scan_code  (scan_code),
      .scan_valid (scan_valid),
      .key_state  (key_state)
   );

   // Kempston interface
   joystick_port u_joystick_port (
      .clk      (clk),
      .rst_n    (rst_n),
      .joyup    (joyup),
      .joydown  (joydown),
      .joyleft  (joyleft),
      .joyright (joyright),
      .joyfire  (joyfire),
      .joy_byte (joy_byte)
   );

   io_read_port u_io_read_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .io_req    (io_req),
      .io_addr   (io_addr),
      .ear       (ear),         // Raw pin, synchronized inside
      .key_state (key_state),
      .joy_byte  (joy_byte),
      .io_ack    (io_ack),
      .io_data   (io_data)
   );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_zx_input -f all.f \
   && ./obj_dir/Vtb_zx_input > sim.log 2>&1
cat sim.log 2>/dev/null
[ -f sim.log ] && ! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== tests/tb_zx_input.sv ====
module tb_zx_input;

   //////////////////////////////////////////////////
   // Local copies of the design constants
   //////////////////////////////////////////////////
   localparam int         NUM_KEYS   = 40;
   localparam logic [7:0] KEMPSTON   = 8'h1F;
   localparam int         SETTLE     = 60;     // Clocks after each stimulus
   localparam int         PS2_HALF   = 20;     // Half a PS/2 clock, in system clocks
   localparam int         MAX_CYCLES = 300 * 500 + 100000;   // 300 ops plus margin

   logic        clk;
   logic        rst_n;
   logic        ps2_clk;
   logic        ps2_data;
   logic        ear;
   logic        joyup;
   logic        joydown;
   logic        joyleft;
   logic        joyright;
   logic        joyfire;
   logic        io_req;
   logic [15:0] io_addr;
   logic        io_ack;
   logic [7:0]  io_data;

   // Reference model state
   logic [7:0]          key_codes [NUM_KEYS];   // Set-2 make codes, row*5+col
   logic [NUM_KEYS-1:0] pressed;
   logic [4:0]          joy_model;              // Fire up down left right, active high
   logic                ear_level;
   int                  cycle_cnt = 0;

   zx_input_top u_zx_input_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .ear      (ear),
      .joyup    (joyup),
      .joydown  (joydown),
      .joyleft  (joyleft),
      .joyright (joyright),
      .joyfire  (joyfire),
      .io_req   (io_req),
      .io_addr  (io_addr),
      .io_ack   (io_ack),
      .io_data  (io_data)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;   // Period 4

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Simulation timed out after %0d clocks", cycle_cnt);
         $display("STATUS: FAIL");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic wait_clocks(input int n);
      repeat (n) @(posedge clk);
      #1;                                  // Drive just after the edge
   endtask

   task automatic check_byte(input logic [7:0] expected, input logic [7:0] actual,
                             input logic [15:0] addr, input string what);
      if (actual !== expected) begin
         $display("ERROR t=%0t addr=%h %s: expected %h got %h",
                  $time, addr, what, expected, actual);
         $display("STATUS: FAIL");
         $fatal(1);
      end
   endtask

   // Start, 8 data LSB first, odd parity, stop
   task automatic send_ps2(input logic [7:0] code, input bit bad_parity);
      logic [10:0] frame;
      frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
      for (int i = 0; i < 11; i++) begin
         ps2_data = frame[i];
         wait_clocks(PS2_HALF / 2);
         ps2_clk = 1'b0;                   // Receiver samples on this fall
         wait_clocks(PS2_HALF);
         ps2_clk = 1'b1;
         wait_clocks(PS2_HALF / 2);
      end
   endtask

   task automatic key_event(input int k, input bit make);
      if (!make)
         send_ps2(8'hF0, 1'b0);            // Break prefix
      send_ps2(key_codes[k], 1'b0);
      pressed[k] = make;
      wait_clocks(SETTLE);
   endtask

   task automatic drive_joy(input logic [4:0] active);
      {joyfire, joyup, joydown, joyleft, joyright} = ~active;   // Pins active low
   endtask

   // Expected read byte, straight from the port rules
   function automatic logic [7:0] expect_byte(input logic [15:0] addr);
      logic [4:0] held;
      held = '0;
      if (addr[0] == 1'b0) begin
         for (int c = 0; c < 5; c++)
            for (int r = 0; r < 8; r++)
               if (!addr[8+r] && pressed[r*5+c])
                  held[c] = 1'b1;
         return {1'b1, ~ear_level, 1'b1, ~held};
      end
      if (addr[7:0] == KEMPSTON)
         return {3'b000, joy_model};
      return 8'hFF;
   endfunction

   // Four-phase read with a random hold
   task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
      int hold;
      hold = 1 + int'($urandom % 20);
      check_byte(8'h00, {7'b0, io_ack}, addr, "ack high before request");
      io_addr = addr;
      io_req  = 1'b1;
      while (!io_ack)
         wait_clocks(1);
      data = io_data;
      ear  = ~ear_level;                   // Pin moves while the CPU holds the bus
      repeat (hold) begin
         wait_clocks(1);
         check_byte(data, io_data, addr, "data moved while held");
         check_byte(8'h01, {7'b0, io_ack}, addr, "ack dropped during hold");
      end
      ear    = ear_level;
      io_req = 1'b0;
      wait_clocks(1);
      check_byte(8'h01, {7'b0, io_ack}, addr, "ack fell with request");
      while (io_ack)
         wait_clocks(1);
   endtask

   task automatic read_check(input logic [15:0] addr, input string what);
      logic [7:0] got;
      cpu_read(addr, got);
      check_byte(expect_byte(addr), got, addr, what);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      int          k;
      int          j;
      logic [4:0]  v5;
      logic [7:0]  lo;
      logic [7:0]  got;
      logic [15:0] addr;
      void'($urandom(24));
      key_codes = '{8'h12, 8'h1A, 8'h22, 8'h21, 8'h2A,   // CAPS Z X C V
                    8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34,   // A S D F G
                    8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C,   // Q W E R T
                    8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,   // 1 2 3 4 5
                    8'h45, 8'h46, 8'h3E, 8'h3D, 8'h36,   // 0 9 8 7 6
                    8'h4D, 8'h44, 8'h43, 8'h3C, 8'h35,   // P O I U Y
                    8'h5A, 8'h4B, 8'h42, 8'h3B, 8'h33,   // ENTER L K J H
                    8'h29, 8'h59, 8'h3A, 8'h31, 8'h32};  // SPACE SYM M N B
      pressed   = '0;
      joy_model = '0;
      ear_level = 1'b0;
      rst_n     = 1'b0;
      ps2_clk   = 1'b1;                    // Idle bus
      ps2_data  = 1'b1;
      ear       = 1'b0;
      io_req    = 1'b0;
      io_addr   = 16'h0000;
      drive_joy(5'b00000);
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      wait_clocks(SETTLE);
      check_byte(8'h00, {7'b0, io_ack}, 16'h0000, "ack after reset");
      read_check(16'h00FE, "all rows after reset");

      // Random make and break
      for (int i = 0; i < 80; i++) begin
         k = int'($urandom % NUM_KEYS);
         key_event(k, !pressed[k]);
         read_check({8'($urandom), 8'($urandom) & 8'hFE}, "random rows");
         read_check(16'h00FE, "all rows");
      end

      // Extended, bad parity and unmapped codes
      if (pressed == '0)
         key_event(0, 1'b1);
      k = 0;
      while (!pressed[k])
         k++;
      send_ps2(8'hE0, 1'b0);
      send_ps2(8'hF0, 1'b0);
      send_ps2(key_codes[k], 1'b0);        // Extended break of a held key
      wait_clocks(SETTLE);
      read_check(16'h00FE, "extended break");
      j = (k + 1) % NUM_KEYS;
      key_event(j, 1'b0);                  // Make sure j is free
      send_ps2(key_codes[j], 1'b1);
      wait_clocks(SETTLE);
      read_check(16'h00FE, "bad parity");
      send_ps2(8'hE0, 1'b0);
      send_ps2(key_codes[j], 1'b0);
      wait_clocks(SETTLE);
      read_check(16'h00FE, "extended make");
      send_ps2(8'h0D, 1'b0);               // Tab
      wait_clocks(SETTLE);
      read_check(16'h00FE, "unmapped make");
      send_ps2(8'hF0, 1'b0);
      send_ps2(8'h76, 1'b0);               // Esc
      wait_clocks(SETTLE);
      read_check(16'h00FE, "unmapped break");
      key_event(j, 1'b1);                  // Prefix flags must be clear again
      read_check(16'h00FE, "make after prefixes");
      read_check(16'hFFFE, "no rows");

      // Joystick values and short glitches
      for (int i = 0; i < 20; i++) begin
         v5 = 5'($urandom);
         drive_joy(v5);
         joy_model = v5;
         wait_clocks(40 + SETTLE);
         read_check({8'($urandom), KEMPSTON}, "joystick");
         drive_joy(v5 ^ 5'(1 + $urandom % 31));
         wait_clocks(8);                   // Shorter than the debounce
         drive_joy(v5);
         wait_clocks(SETTLE);
         read_check({8'($urandom), KEMPSTON}, "joystick glitch");
      end

      // EAR and fixed bits
      for (int i = 0; i < 12; i++) begin
         ear_level = 1'($urandom);
         ear       = ear_level;
         wait_clocks(SETTLE);
         addr = {8'($urandom), 8'($urandom) & 8'hFE};
         cpu_read(addr, got);
         check_byte(expect_byte(addr), got, addr, "ear bit");
      end

      // Unused odd ports float
      for (int i = 0; i < 30; i++) begin
         lo = 8'($urandom) | 8'h01;
         if (lo == KEMPSTON)
            lo = 8'h3F;
         addr = {8'($urandom), lo};
         cpu_read(addr, got);
         check_byte(8'hFF, got, addr, "unused port");
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule
